// File: Makefile
# Verilator build and run for the register path testbench

VERILATOR ?= verilator
TOP       ?= tb_ps_sys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "test passed"; \
	else \
	  echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+hdl
hdl/sys_bus_pkg.sv
hdl/sys_bus_if.sv
hdl/axi_sys_bridge.sv
hdl/sys_bus_decoder.sv
hdl/sys_bus_join.sv
hdl/reg_bank.sv
hdl/ps_sys_top.sv
verif/tb_ps_sys.sv

// File: hdl/axi_sys_bridge.sv
/*
 * AXI to system bus bridge
 * single-beat AXI slave, one transaction in flight, writes before reads
 * each accepted transaction becomes one wen or ren pulse on the bus
 */

`timescale 1ns/1ps
`default_nettype none

module axi_sys_bridge (
  input  logic                   clk_i,      // bus clock
  input  logic                   rst_n_i,    // async reset
  // write address and data
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  sys_bus_pkg::sys_addr_t awaddr_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  sys_bus_pkg::sys_data_t wdata_i,
  input  sys_bus_pkg::sys_sel_t  wstrb_i,
  // write response
  output logic                   bvalid_o,
  input  logic                   bready_i,
  output sys_bus_pkg::axi_resp_t bresp_o,
  // read address
  input  logic                   arvalid_i,
  output logic                   arready_o,
  input  sys_bus_pkg::sys_addr_t araddr_i,
  // read data
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output sys_bus_pkg::sys_data_t rdata_o,
  output sys_bus_pkg::axi_resp_t rresp_o,
  // system bus master
  sys_bus_if.m                   bus
);

  sys_bus_pkg::bridge_state_t state_q, state_d;
  sys_bus_pkg::sys_addr_t     addr_q;      // latched access address
  sys_bus_pkg::sys_data_t     wdata_q;     // latched write data
  sys_bus_pkg::sys_sel_t      sel_q;       // latched strobes
  sys_bus_pkg::sys_data_t     rdata_q;     // captured read data
  logic                       err_q;       // captured bus error
  logic                       is_wr_q;     // current transaction is a write
  logic                       wr_hs;       // aw+w accepted this cycle
  logic                       rd_hs;       // ar accepted this cycle
  logic                       resp_taken;  // b or r handshake

  //////////////////////////////////////////////////////////////////////
  // AXI handshakes
  //////////////////////////////////////////////////////////////////////

  assign wr_hs = (state_q == sys_bus_pkg::IDLE) && awvalid_i && wvalid_i;  // pair only
  assign rd_hs = (state_q == sys_bus_pkg::IDLE) && arvalid_i
               && !(awvalid_i && wvalid_i);                                 // write wins

  assign awready_o = wr_hs;
  assign wready_o  = wr_hs;
  assign arready_o = rd_hs;

  assign bvalid_o = (state_q == sys_bus_pkg::RESP) &&  is_wr_q;
  assign rvalid_o = (state_q == sys_bus_pkg::RESP) && !is_wr_q;
  assign bresp_o  = err_q ? 2'b10 : 2'b00;  // slverr on bus error
  assign rresp_o  = err_q ? 2'b10 : 2'b00;
  assign rdata_o  = rdata_q;                // held through back-pressure

  assign resp_taken = (bvalid_o && bready_i) || (rvalid_o && rready_i);

  //////////////////////////////////////////////////////////////////////
  // transaction FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      sys_bus_pkg::IDLE: begin
        if (wr_hs)      state_d = sys_bus_pkg::WR_REQ;
        else if (rd_hs) state_d = sys_bus_pkg::RD_REQ;
      end
      sys_bus_pkg::WR_REQ,
      sys_bus_pkg::RD_REQ:   state_d = sys_bus_pkg::WAIT_ACK;  // pulse is one cycle
      sys_bus_pkg::WAIT_ACK: if (bus.ack) state_d = sys_bus_pkg::RESP;
      sys_bus_pkg::RESP:     if (resp_taken) state_d = sys_bus_pkg::IDLE;
      default:               state_d = sys_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= sys_bus_pkg::IDLE;
      is_wr_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wr_hs || rd_hs) is_wr_q <= wr_hs;
      if ((state_q == sys_bus_pkg::WAIT_ACK) && bus.ack) err_q <= bus.err;
    end
  end

  // payload capture
  always_ff @(posedge clk_i) begin
    if (wr_hs || rd_hs) begin
      addr_q  <= wr_hs ? awaddr_i : araddr_i;
      wdata_q <= wdata_i;
      sel_q   <= wr_hs ? wstrb_i : '1;  // reads take the whole word
    end
    if ((state_q == sys_bus_pkg::WAIT_ACK) && bus.ack) rdata_q <= bus.rdata;
  end

  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.sel   = sel_q;
  assign bus.wen   = (state_q == sys_bus_pkg::WR_REQ);
  assign bus.ren   = (state_q == sys_bus_pkg::RD_REQ);

  a_ack_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bus.wen || bus.ren) |=> bus.ack);
  a_ack_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.ack |-> (state_q == sys_bus_pkg::WAIT_ACK));

endmodule

`default_nettype wire

// File: hdl/ps_sys_top.sv
/*
 * processor to fabric register path
 * AXI bridge, address decoder, register banks and response join
 */

`timescale 1ns/1ps
`default_nettype none

`include "sys_bus_consts.svh"

module ps_sys_top (
  input  logic                   clk_i,      // bus clock
  input  logic                   rst_n_i,    // async reset
  input  logic                   awvalid_i,
  output logic                   awready_o,
  input  sys_bus_pkg::sys_addr_t awaddr_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,
  input  sys_bus_pkg::sys_data_t wdata_i,
  input  sys_bus_pkg::sys_sel_t  wstrb_i,
  output logic                   bvalid_o,
  input  logic                   bready_i,
  output sys_bus_pkg::axi_resp_t bresp_o,
  input  logic                   arvalid_i,
  output logic                   arready_o,
  input  sys_bus_pkg::sys_addr_t araddr_i,
  output logic                   rvalid_o,
  input  logic                   rready_i,
  output sys_bus_pkg::sys_data_t rdata_o,
  output sys_bus_pkg::axi_resp_t rresp_o
);

  sys_bus_if up_bus ();                   // bridge side
  sys_bus_if bank_bus [`NUM_BANKS] ();    // one per bank
  logic      miss;                        // decoder to join

  axi_sys_bridge bridge_i (
    .clk_i     (clk_i    ), .rst_n_i   (rst_n_i  ),
    .awvalid_i (awvalid_i), .awready_o (awready_o), .awaddr_i (awaddr_i),
    .wvalid_i  (wvalid_i ), .wready_o  (wready_o ), .wdata_i  (wdata_i ),
    .wstrb_i   (wstrb_i  ),
    .bvalid_o  (bvalid_o ), .bready_i  (bready_i ), .bresp_o  (bresp_o ),
    .arvalid_i (arvalid_i), .arready_o (arready_o), .araddr_i (araddr_i),
    .rvalid_o  (rvalid_o ), .rready_i  (rready_i ), .rdata_o  (rdata_o ),
    .rresp_o   (rresp_o  ),
    .bus       (up_bus   )
  );

  sys_bus_decoder decoder_i (
    .clk_i   (clk_i   ), .rst_n_i (rst_n_i ),
    .up      (up_bus  ), .banks   (bank_bus), .miss_o (miss)
  );

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    reg_bank #(.BANK_IDX(i)) bank_i (
      .clk_i (clk_i), .rst_n_i (rst_n_i), .bus (bank_bus[i])
    );
  end

  sys_bus_join join_i (
    .clk_i   (clk_i   ), .rst_n_i (rst_n_i ), .miss_i (miss),
    .banks   (bank_bus), .up      (up_bus  )
  );

endmodule

`default_nettype wire

// File: hdl/reg_bank.sv
/*
 * register bank
 * read-only id word at register 0, byte-strobed registers 1 to 7
 * every request is acknowledged in the following cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "sys_bus_consts.svh"

module reg_bank #(
  parameter int unsigned BANK_IDX = 0  // own bank index, below 16
) (
  input  logic clk_i,                  // bus clock
  input  logic rst_n_i,                // async reset
  sys_bus_if.s bus                     // steered request from decoder
);

  logic [`REG_W-1:0]      idx;                       // register index
  sys_bus_pkg::sys_data_t id_word;                   // register 0 value
  sys_bus_pkg::sys_data_t regs_q [1:`BANK_REGS-1];   // writable registers
  sys_bus_pkg::sys_data_t rdata_q;                   // read data out
  logic                   ack_q;
  logic                   err_q;

  assign idx     = bus.addr[`REG_LSB +: `REG_W];
  assign id_word = sys_bus_pkg::sys_data_t'(`BANK_ID_BASE + BANK_IDX);

  //////////////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 1; r < `BANK_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (bus.wen && (idx != '0)) begin
      for (int b = 0; b < `SYS_SW; b++) begin
        if (bus.sel[b]) regs_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];  // byte lane
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= bus.wen | bus.ren;          // fixed one cycle latency
      err_q <= bus.wen & (idx == '0);      // id word is read-only
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.wen || bus.ren) begin
      if (!bus.ren)        rdata_q <= '0;  // writes return no data
      else if (idx == '0)  rdata_q <= id_word;
      else                 rdata_q <= regs_q[idx];
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// File: hdl/sys_bus_consts.svh
/*
 * system bus constants
 * widths, bank count and the region/register address map
 */

`ifndef SYS_BUS_CONSTS_SVH
`define SYS_BUS_CONSTS_SVH

`define SYS_AW        32            // address width
`define SYS_DW        32            // data width
`define SYS_SW        4             // byte strobes
`define NUM_BANKS     4             // register banks behind the decoder
`define REGION_LSB    12            // region field, 4 kB per bank
`define REGION_W      4             // 16 regions, upper ones unmapped
`define REG_LSB       2             // word aligned registers
`define REG_W         3             // register index width
`define BANK_REGS     8             // registers per bank
`define BANK_ID_BASE  32'hB0C0_0000 // id word, bank index added

`endif

// File: hdl/sys_bus_decoder.sv
/*
 * system bus address decoder
 * fans the request out by region, flags accesses to unmapped regions
 */

`timescale 1ns/1ps
`default_nettype none

`include "sys_bus_consts.svh"

module sys_bus_decoder (
  input  logic   clk_i,                   // bus clock
  input  logic   rst_n_i,                 // async reset
  sys_bus_if.req up,                      // from the bridge
  sys_bus_if.dn  banks [`NUM_BANKS],      // to the register banks
  output logic   miss_o                   // request hit no bank
);

  sys_bus_pkg::bank_idx_t    region;       // region field of the address
  logic [`NUM_BANKS-1:0]     hit;          // region matches bank
  logic [2*`NUM_BANKS-1:0]   bank_en;      // wen and ren forwarded per bank
  logic                      req;          // any request this cycle

  assign region = up.addr[`REGION_LSB +: `REGION_W];
  assign req    = up.wen | up.ren;

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_fan
    assign hit[i]         = (region == sys_bus_pkg::bank_idx_t'(i));
    assign bank_en[2*i]   = up.wen & hit[i];
    assign bank_en[2*i+1] = up.ren & hit[i];

    // payload goes to every bank
    assign banks[i].addr  = up.addr;
    assign banks[i].wdata = up.wdata;
    assign banks[i].sel   = up.sel;
    assign banks[i].wen   = bank_en[2*i];
    assign banks[i].ren   = bank_en[2*i+1];
  end

  // regions at or above NUM_BANKS hit no bank and go to the join
  assign miss_o = req & ~(|hit);

  a_one_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(bank_en));

endmodule

`default_nettype wire

// File: hdl/sys_bus_if.sv
/*
 * system bus
 * one-cycle wen/ren request, ack with err and rdata one cycle later
 */

`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if;

  sys_bus_pkg::sys_addr_t addr;   // access address
  sys_bus_pkg::sys_data_t wdata;  // write data
  sys_bus_pkg::sys_sel_t  sel;    // byte strobes
  logic                   wen;    // write pulse
  logic                   ren;    // read pulse
  sys_bus_pkg::sys_data_t rdata;  // read data, valid with ack
  logic                   err;    // error, valid with ack
  logic                   ack;    // access done

  modport m   (output addr, wdata, sel, wen, ren, input rdata, err, ack);  // bridge
  modport req (input addr, wdata, sel, wen, ren);                          // decoder up
  modport rsp (output rdata, err, ack);                                    // join up
  modport dn  (output addr, wdata, sel, wen, ren);                         // decoder down
  modport s   (input addr, wdata, sel, wen, ren, output rdata, err, ack);  // bank
  modport mon (input rdata, err, ack);                                     // join down

endinterface

`default_nettype wire

// File: hdl/sys_bus_join.sv
/*
 * system bus response join
 * merges bank acks and read data, answers decoder misses with err
 */

`timescale 1ns/1ps
`default_nettype none

`include "sys_bus_consts.svh"

module sys_bus_join (
  input  logic   clk_i,                   // bus clock
  input  logic   rst_n_i,                 // async reset
  input  logic   miss_i,                  // unmapped request from decoder
  sys_bus_if.mon banks [`NUM_BANKS],      // bank responses
  sys_bus_if.rsp up                       // to the bridge
);

  logic [`NUM_BANKS-1:0]  ack_vec;                    // bank acks
  logic [`NUM_BANKS-1:0]  err_vec;                    // bank errors, ack gated
  sys_bus_pkg::sys_data_t rdata_arr [`NUM_BANKS];     // ack gated read data
  sys_bus_pkg::sys_data_t rdata_or;                   // merged read data
  logic                   miss_q;                     // miss ack, one cycle late

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_mon
    assign ack_vec[i]   = banks[i].ack;
    assign err_vec[i]   = banks[i].ack & banks[i].err;
    assign rdata_arr[i] = banks[i].ack ? banks[i].rdata : '0;
  end

  // and-or mux, only the acking bank contributes
  always_comb begin
    rdata_or = '0;
    for (int k = 0; k < `NUM_BANKS; k++) begin
      rdata_or = rdata_or | rdata_arr[k];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) miss_q <= 1'b0;
    else          miss_q <= miss_i;  // same latency as a bank
  end

  assign up.ack   = (|ack_vec) | miss_q;
  assign up.err   = (|err_vec) | miss_q;
  assign up.rdata = rdata_or;        // zero on a miss

  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(ack_vec) && !((|ack_vec) && miss_q));

endmodule

`default_nettype wire

// File: hdl/sys_bus_pkg.sv
/*
 * system bus types
 * address, data, strobe, response and bridge state types
 */

`default_nettype none

`include "sys_bus_consts.svh"

package sys_bus_pkg;

  typedef logic [`SYS_AW-1:0]   sys_addr_t;  // byte address
  typedef logic [`SYS_DW-1:0]   sys_data_t;  // data word
  typedef logic [`SYS_SW-1:0]   sys_sel_t;   // byte strobes
  typedef logic [1:0]           axi_resp_t;  // 0 okay, 2 slverr
  typedef logic [`REGION_W-1:0] bank_idx_t;  // region index

  typedef enum logic [2:0] {
    IDLE, WR_REQ, RD_REQ, WAIT_ACK, RESP
  } bridge_state_t;

endpackage

`default_nettype wire

// File: verif/tb_ps_sys.sv
/*
 * testbench for the processor to fabric register path
 * AXI driver tasks, a reference register model and a response checker
 */

`timescale 1ns/1ps
`default_nettype none

`include "sys_bus_consts.svh"

module tb_ps_sys;

  localparam int TIMEOUT = 50;             // cycles allowed per wait

  logic clk;
  logic rst_n;
  logic awvalid, awready, wvalid, wready;  // write address and data
  logic bvalid, bready;                    // write response
  logic arvalid, arready, rvalid, rready;  // read channels
  sys_bus_pkg::sys_addr_t awaddr, araddr;
  sys_bus_pkg::sys_data_t wdata, rdata;
  sys_bus_pkg::sys_sel_t  wstrb;
  sys_bus_pkg::axi_resp_t bresp, rresp;

  integer seed;
  int     errors;
  int     timeouts;
  int     b_count;                         // write responses taken so far
  int     b_seen_at_r;                     // b_count at the last read beat

  sys_bus_pkg::sys_data_t ref_regs [0:15][0:`BANK_REGS-1];  // model, region x register
  sys_bus_pkg::axi_resp_t exp_b_q [$];     // expected bresp, in order
  logic [33:0]            exp_r_q [$];     // expected {rresp, rdata}

  ps_sys_top dut_i (
    .clk_i     (clk    ), .rst_n_i   (rst_n  ),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i  (wvalid ), .wready_o  (wready ), .wdata_i  (wdata ),
    .wstrb_i   (wstrb  ),
    .bvalid_o  (bvalid ), .bready_i  (bready ), .bresp_o  (bresp ),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o  (rvalid ), .rready_i  (rready ), .rdata_o  (rdata ),
    .rresp_o   (rresp  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                 // 4 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic sys_bus_pkg::sys_addr_t make_addr(input int unsigned region,
                                                      input int unsigned idx);
    return sys_bus_pkg::sys_addr_t'((region << `REGION_LSB) | (idx << `REG_LSB));
  endfunction

  function automatic sys_bus_pkg::sys_data_t merge_bytes(input sys_bus_pkg::sys_data_t old_v,
                                                        input sys_bus_pkg::sys_data_t new_v,
                                                        input sys_bus_pkg::sys_sel_t strb);
    sys_bus_pkg::sys_data_t m;
    m = old_v;
    for (int b = 0; b < `SYS_SW; b++) begin
      if (strb[b]) m[8*b +: 8] = new_v[8*b +: 8];  // strobed lane takes new byte
    end
    return m;
  endfunction

  // expected {resp, data} of one access against the current model
  function automatic logic [33:0] ref_access(input logic is_wr,
                                             input sys_bus_pkg::sys_addr_t addr);
    sys_bus_pkg::bank_idx_t bank;
    logic [`REG_W-1:0]      idx;
    bank = addr[`REGION_LSB +: `REGION_W];
    idx  = addr[`REG_LSB +: `REG_W];
    if (32'(bank) >= `NUM_BANKS) return {2'b10, 32'h0};  // unmapped region
    if (is_wr && idx == '0)      return {2'b10, 32'h0};  // id word is read-only
    if (is_wr)                   return {2'b00, 32'h0};
    if (idx == '0)               return {2'b00, `BANK_ID_BASE + 32'(bank)};
    return {2'b00, ref_regs[bank][idx]};
  endfunction

  task automatic expect_write(input sys_bus_pkg::sys_addr_t addr,
                              input sys_bus_pkg::sys_data_t data,
                              input sys_bus_pkg::sys_sel_t strb);
    logic [33:0]            res;
    sys_bus_pkg::bank_idx_t bank;
    logic [`REG_W-1:0]      idx;
    res  = ref_access(1'b1, addr);
    bank = addr[`REGION_LSB +: `REGION_W];
    idx  = addr[`REG_LSB +: `REG_W];
    exp_b_q.push_back(res[33:32]);
    if (res[33:32] == 2'b00) ref_regs[bank][idx] = merge_bytes(ref_regs[bank][idx], data, strb);
  endtask

  task automatic expect_read(input sys_bus_pkg::sys_addr_t addr);
    exp_r_q.push_back(ref_access(1'b0, addr));
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI driver tasks
  //////////////////////////////////////////////////////////////////////

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: %s never happened", $time, what);
  endtask

  task automatic axi_write(input sys_bus_pkg::sys_addr_t addr,
                           input sys_bus_pkg::sys_data_t data,
                           input sys_bus_pkg::sys_sel_t strb, input int stall);
    int t;
    @(posedge clk);
    #1;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    t = 0;
    @(negedge clk);
    while (!(awready && wready) && t < TIMEOUT) begin
      t++;
      @(negedge clk);
    end
    if (t >= TIMEOUT) report_timeout("write address and data handshake");
    @(posedge clk);                        // handshake edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    t = 0;
    @(negedge clk);
    while (!bvalid && t < TIMEOUT) begin
      t++;
      @(negedge clk);
    end
    if (t >= TIMEOUT) report_timeout("write response valid");
    repeat (stall) @(negedge clk);         // back-pressure on bready
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input sys_bus_pkg::sys_addr_t addr, input int stall);
    int t;
    @(posedge clk);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    t = 0;
    @(negedge clk);
    while (!arready && t < TIMEOUT) begin
      t++;
      @(negedge clk);
    end
    if (t >= TIMEOUT) report_timeout("read address handshake");
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    t = 0;
    @(negedge clk);
    while (!rvalid && t < TIMEOUT) begin
      t++;
      @(negedge clk);
    end
    if (t >= TIMEOUT) report_timeout("read data valid");
    repeat (stall) @(negedge clk);         // back-pressure on rready
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic do_write(input sys_bus_pkg::sys_addr_t addr, input sys_bus_pkg::sys_data_t data,
                          input sys_bus_pkg::sys_sel_t strb, input int stall);
    expect_write(addr, data, strb);
    axi_write(addr, data, strb, stall);
  endtask

  task automatic do_read(input sys_bus_pkg::sys_addr_t addr, input int stall);
    expect_read(addr);
    axi_read(addr, stall);
  endtask

  //////////////////////////////////////////////////////////////////////
  // response checker, sampled mid-cycle
  //////////////////////////////////////////////////////////////////////

  logic                   hold_b, hold_r;  // response stalled last cycle
  sys_bus_pkg::axi_resp_t held_bresp, held_rresp;
  sys_bus_pkg::sys_data_t held_rdata;

  always @(negedge clk) begin : compare_beats
    sys_bus_pkg::axi_resp_t exp_b;
    logic [33:0]            exp_r;
    if (!rst_n) begin
      hold_b = 1'b0;
      hold_r = 1'b0;
    end else begin
      if (bvalid || rvalid) begin
        assert ({awready, wready, arready} == 3'b000) else begin
          errors++;
          $display("Fail at %0t: {awready_o,wready_o,arready_o} got %b expected 000",
                   $time, {awready, wready, arready});
        end
      end
      if (hold_b) begin
        assert (bvalid) else begin
          errors++;
          $display("Error at %0t: bvalid_o dropped before bready_i", $time);
        end
        assert (bresp == held_bresp) else begin
          errors++;
          $display("Fail at %0t: bresp_o got %0h expected %0h", $time, bresp, held_bresp);
        end
      end
      if (hold_r) begin
        assert (rvalid) else begin
          errors++;
          $display("Error at %0t: rvalid_o dropped before rready_i", $time);
        end
        assert (rdata == held_rdata && rresp == held_rresp) else begin
          errors++;
          $display("Fail at %0t: rdata_o/rresp_o got %h/%0h expected %h/%0h",
                   $time, rdata, rresp, held_rdata, held_rresp);
        end
      end
      if (bvalid && bready) begin
        if (exp_b_q.size() == 0) begin
          errors++;
          $display("Error at %0t: write response with no write outstanding", $time);
        end else begin
          exp_b = exp_b_q.pop_front();
          assert (bresp == exp_b) else begin
            errors++;
            $display("Fail at %0t: bresp_o got %0h expected %0h", $time, bresp, exp_b);
          end
          b_count++;
        end
      end
      if (rvalid && rready) begin
        if (exp_r_q.size() == 0) begin
          errors++;
          $display("Error at %0t: read data with no read outstanding", $time);
        end else begin
          exp_r = exp_r_q.pop_front();
          assert (rresp == exp_r[33:32]) else begin
            errors++;
            $display("Fail at %0t: rresp_o got %0h expected %0h", $time, rresp, exp_r[33:32]);
          end
          assert (rdata == exp_r[31:0]) else begin
            errors++;
            $display("Fail at %0t: rdata_o got %h expected %h", $time, rdata, exp_r[31:0]);
          end
          b_seen_at_r = b_count;
        end
      end
      hold_b     = bvalid && !bready;
      hold_r     = rvalid && !rready;
      held_bresp = bresp;
      held_rresp = rresp;
      held_rdata = rdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    sys_bus_pkg::sys_addr_t a;
    sys_bus_pkg::sys_data_t d;
    sys_bus_pkg::sys_sel_t  s;
    int                     stall;
    int                     b_before;
    seed        = 32'h4092_5dea;
    errors      = 0;
    timeouts    = 0;
    b_count     = 0;
    b_seen_at_r = 0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    for (int g = 0; g < 16; g++) begin
      for (int r = 0; r < `BANK_REGS; r++) ref_regs[g][r] = '0;
    end
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // id words and reset values
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int r = 0; r < `BANK_REGS; r++) do_read(make_addr(b, r), 0);
    end

    // full word writes, then read everything back
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int r = 1; r < `BANK_REGS; r++) begin
        d = $random(seed);
        do_write(make_addr(b, r), d, 4'hF, 0);
      end
    end
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int r = 1; r < `BANK_REGS; r++) do_read(make_addr(b, r), 0);
    end

    // partial strobes merge by byte
    repeat (16) begin
      a = make_addr({$random(seed)} % `NUM_BANKS, 1 + {$random(seed)} % 7);
      d = $random(seed);
      s = sys_bus_pkg::sys_sel_t'($random(seed));
      do_write(a, d, s, 0);
      do_read(a, 0);
    end

    // read-only id word and unmapped regions
    for (int b = 0; b < `NUM_BANKS; b++) begin
      do_write(make_addr(b, 0), $random(seed), 4'hF, 0);
      do_read(make_addr(b, 0), 0);
    end
    for (int g = `NUM_BANKS; g < 16; g++) begin
      a = make_addr(g, {$random(seed)} % 8);
      do_write(a, $random(seed), 4'hF, 0);
      do_read(a, 0);
    end

    // back-pressure on both response channels
    repeat (12) begin
      a     = make_addr({$random(seed)} % `NUM_BANKS, 1 + {$random(seed)} % 7);
      stall = {$random(seed)} % 8;
      do_write(a, $random(seed), 4'hF, stall);
      stall = {$random(seed)} % 8;
      do_read(a, stall);
    end

    // write and read raised together, write goes first
    repeat (6) begin
      a = make_addr({$random(seed)} % `NUM_BANKS, 1 + {$random(seed)} % 7);
      d = $random(seed);
      expect_write(a, d, 4'hF);
      expect_read(a);
      b_before = b_count;
      stall    = {$random(seed)} % 8;
      fork
        axi_write(a, d, 4'hF, stall);
        axi_read(a, {$random(seed)} % 8);
      join
      assert (b_seen_at_r == b_before + 1) else begin
        errors++;
        $display("Error at %0t: read response came before the write response", $time);
      end
    end

    repeat (4) @(posedge clk);
    if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      errors++;
      $display("Error: %0d write and %0d read responses never arrived",
               exp_b_q.size(), exp_r_q.size());
    end
    $display("closing count: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
